//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f spi_subsys.f --top-module tb_spi_subsys -o sim_spi
obj_dir/sim_spi > sim.log
cat sim.log
if grep -q '\*\* FAIL \*\*' sim.log; then
	exit 1
fi
grep -q '\*\* PASS \*\*' sim.log

//--- spi_subsys.f
src/spi_pkg.sv
src/spi_byte_fifo.sv
src/spi_byte_engine.sv
src/spi_frame_ctrl.sv
src/spi_subsys.sv
testbench/spi_slave_model.sv
testbench/spi_checker.sv
testbench/tb_spi_subsys.sv

//--- src/spi_byte_engine.sv
//**********************************************************************
// one-byte spi shifter, msb first, mode taken from cfg at runtime
// cfg must not change during a byte; byte_start only taken when idle
// latency set by clk_div, end marked by byte_done
//**********************************************************************
`timescale 1ns/1ps

module spi_byte_engine
	import spi_pkg::*;
(
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  spi_cfg_t          cfg,			// mode and divider
	input  logic              byte_start,	// one-cycle pulse
	input  logic [BYTE_W-1:0] byte_tx,		// loaded on byte_start
	input  logic              miso,
	output logic              byte_done,	// one-cycle pulse
	output logic [BYTE_W-1:0] byte_rx,		// valid with byte_done
	output logic              sclk,
	output logic              mosi
);

	typedef enum logic [2:0] {
		S_IDLE,									// waiting for byte_start
		S_WAIT,									// counting half period
		S_EDGE,									// sclk toggles here
		S_LAST,									// trailing half after edge 16
		S_DONE									// byte_done cycle
	} state_t;

	state_t                         state;
	logic [DIV_W-1:0]               cnt_clk;	// half period counter
	logic [$clog2(2*BYTE_W)-1:0]    cnt_edge;	// edge about to happen
	logic [BYTE_W-1:0]              mosi_shift;
	logic [BYTE_W-1:0]              miso_shift;
	logic                           half_end;
	logic                           shift_now;
	logic                           sample_now;

	assign half_end  = (cnt_clk == cfg.clk_div);

	// cpha 1 keeps the msb through edge 0, shifts on later leading edges
	assign shift_now = (state == S_EDGE) &&
		(cfg.cpha ? (cnt_edge != '0 && !cnt_edge[0]) : cnt_edge[0]);
	assign sample_now = (state == S_EDGE) &&
		(cfg.cpha ? cnt_edge[0] : !cnt_edge[0]);	// opposite edges to shift

	assign mosi      = mosi_shift[BYTE_W-1];	// msb first
	assign byte_rx   = miso_shift;
	assign byte_done = (state == S_DONE);

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (byte_start) state <= S_WAIT;
				S_WAIT: if (half_end) state <= S_EDGE;
				S_EDGE: begin
					if (&cnt_edge)
						state <= S_LAST;	// 16th edge done
					else
						state <= S_WAIT;
				end
				S_LAST: if (half_end) state <= S_DONE;
				S_DONE: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			cnt_clk <= '0;
		else if (state == S_WAIT || state == S_LAST)
			cnt_clk <= cnt_clk + 1'b1;
		else
			cnt_clk <= '0;					// restart each half
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n || state == S_IDLE)
			cnt_edge <= '0;
		else if (state == S_EDGE)
			cnt_edge <= cnt_edge + 1'b1;	// wraps after last edge
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n || state == S_IDLE)
			sclk <= cfg.cpol;				// rest level
		else if (state == S_EDGE)
			sclk <= ~sclk;
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			mosi_shift <= '0;				// mosi low out of reset
		else if (state == S_IDLE && byte_start)
			mosi_shift <= byte_tx;
		else if (shift_now)
			mosi_shift <= {mosi_shift[BYTE_W-2:0], 1'b0};
	end

	always_ff @(posedge sys_clk) begin
		if (state == S_IDLE && byte_start)
			miso_shift <= '0;
		else if (sample_now)
			miso_shift <= {miso_shift[BYTE_W-2:0], miso};	// msb arrives first
	end

endmodule

//--- src/spi_byte_fifo.sv
//**********************************************************************
// register-array byte fifo; write to full and read from empty dropped
// rd_data shows the head, valid only while not empty
//**********************************************************************
`timescale 1ns/1ps

module spi_byte_fifo
	import spi_pkg::*;
(
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  logic              wr,			// push strobe
	input  logic [BYTE_W-1:0] wr_data,
	input  logic              rd,			// pop strobe
	output logic [BYTE_W-1:0] rd_data,		// head of queue
	output logic [CNT_W-1:0]  count,
	output logic              full,
	output logic              empty
);

	logic [BYTE_W-1:0]  mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;				// wraps with depth 2**aw
	logic [FIFO_AW-1:0] rd_ptr;
	logic               wr_ok;
	logic               rd_ok;

	assign full    = (count == CNT_W'(FIFO_DEPTH));
	assign empty   = (count == '0);
	assign wr_ok   = wr && !full;
	assign rd_ok   = rd && !empty;
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge sys_clk) begin
		if (wr_ok)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_ok, rd_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;		// none, or both at once
			endcase
		end
	end

endmodule

//--- src/spi_frame_ctrl.sv
//**********************************************************************
// frame sequencer: cs_n setup, byte loop, cs_n hold, frame_done
// start taken only when idle with 0 < frame_len <= tx_count
//**********************************************************************
`timescale 1ns/1ps

module spi_frame_ctrl
	import spi_pkg::*;
(
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  logic              start,		// one-cycle strobe
	input  logic [LEN_W-1:0]  frame_len,
	input  logic [CNT_W-1:0]  tx_count,		// bytes buffered for transmit
	input  logic [BYTE_W-1:0] tx_head,		// transmit fifo head
	input  logic              byte_done,
	input  logic [BYTE_W-1:0] byte_rx,
	output logic              busy,
	output logic              frame_done,	// one-cycle pulse
	output logic              cs_n,
	output logic              tx_pop,
	output logic              byte_start,
	output logic [BYTE_W-1:0] byte_tx,
	output logic              rx_push,
	output logic [BYTE_W-1:0] rx_byte
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_SETUP,								// cs_n low, before first byte
		S_RUN,									// byte_start cycle
		S_WAIT,									// byte in flight
		S_HOLD									// cs_n low after last byte
	} state_t;

	state_t           state;
	logic [LEN_W-1:0] bytes_left;				// including the one in flight
	logic [CYC_W-1:0] cyc_cnt;					// setup/hold down counter
	logic             accept;

	assign accept = (state == S_IDLE) && start && (frame_len != '0) &&
		(frame_len <= LEN_W'(tx_count));

	assign busy       = (state != S_IDLE);
	assign byte_start = (state == S_RUN);
	assign tx_pop     = byte_start;				// head consumed as it is loaded
	assign byte_tx    = tx_head;
	assign rx_push    = byte_done && (state == S_WAIT);
	assign rx_byte    = byte_rx;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state      <= S_IDLE;
			bytes_left <= '0;
			cyc_cnt    <= '0;
			cs_n       <= 1'b1;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;				// default, pulses in hold
			case (state)
				S_IDLE: begin
					if (accept) begin
						state      <= S_SETUP;
						bytes_left <= frame_len;
						cyc_cnt    <= CYC_W'(CS_SETUP_CYC - 1);
						cs_n       <= 1'b0;	// falls with busy
					end
				end
				S_SETUP: begin
					if (cyc_cnt == '0)
						state <= S_RUN;
					else
						cyc_cnt <= cyc_cnt - 1'b1;
				end
				S_RUN: state <= S_WAIT;
				S_WAIT: begin
					if (byte_done) begin
						bytes_left <= bytes_left - 1'b1;
						if (bytes_left == LEN_W'(1)) begin
							state   <= S_HOLD;	// last byte back
							cyc_cnt <= CYC_W'(CS_HOLD_CYC - 1);
						end else begin
							state <= S_RUN;		// next byte right away
						end
					end
				end
				S_HOLD: begin
					if (cyc_cnt == CYC_W'(1)) begin
						cs_n       <= 1'b1;		// rises with frame_done
						frame_done <= 1'b1;
					end
					if (cyc_cnt == '0)
						state <= S_IDLE;		// busy drops a clock later
					else
						cyc_cnt <= cyc_cnt - 1'b1;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

//--- src/spi_pkg.sv
//**********************************************************************
// shared widths, timing constants and bus structs of the spi master
// only 8-bit words; frame length 1..FIFO_DEPTH bytes
// setup/hold counts must fit CYC_W bits and be at least 2
//**********************************************************************
package spi_pkg;

	localparam int BYTE_W       = 8;			// data word width
	localparam int FIFO_DEPTH   = 8;			// bytes per buffer
	localparam int FIFO_AW      = 3;			// buffer address width
	localparam int CNT_W        = FIFO_AW + 1;	// fill count, 0..depth
	localparam int LEN_W        = 4;			// frame length field
	localparam int DIV_W        = 16;			// clock divider width
	localparam int CYC_W        = 3;			// setup/hold counter width
	localparam int CS_SETUP_CYC = 4;			// cs_n fall to first byte_start
	localparam int CS_HOLD_CYC  = 4;			// last byte_done to cs_n rise

	// runtime mode, held stable while busy
	typedef struct packed {
		logic             cpol;					// sclk idle level
		logic             cpha;					// 0 samples on leading edge
		logic [DIV_W-1:0] clk_div;				// half period = clk_div+2
	} spi_cfg_t;

	// bus outputs
	typedef struct packed {
		logic cs_n;								// active low select
		logic sclk;
		logic mosi;
	} spi_pins_t;

endpackage

//--- src/spi_subsys.sv
//**********************************************************************
// spi master top: tx/rx byte buffers, frame sequencer, byte shifter
// single slave; cfg must stay stable while busy
//**********************************************************************
`timescale 1ns/1ps

module spi_subsys
	import spi_pkg::*;
(
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  spi_cfg_t          cfg,
	input  logic              tx_wr,
	input  logic [BYTE_W-1:0] tx_data,
	output logic              tx_full,
	input  logic              start,
	input  logic [LEN_W-1:0]  frame_len,
	output logic              busy,
	output logic              frame_done,
	input  logic              rx_rd,
	output logic [BYTE_W-1:0] rx_data,
	output logic              rx_empty,
	output spi_pins_t         pins,
	input  logic              miso
);

	logic              tx_pop;
	logic [BYTE_W-1:0] tx_head;
	logic [CNT_W-1:0]  tx_count;
	logic              rx_push;
	logic [BYTE_W-1:0] rx_byte;
	logic              byte_start;
	logic [BYTE_W-1:0] byte_tx;
	logic              byte_done;
	logic [BYTE_W-1:0] byte_rx;
	logic              cs_n;
	logic              sclk;
	logic              mosi;

	assign pins = '{cs_n: cs_n, sclk: sclk, mosi: mosi};

	spi_byte_fifo tx_fifo_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.wr        (tx_wr),
		.wr_data   (tx_data),
		.rd        (tx_pop),
		.rd_data   (tx_head),
		.count     (tx_count),		// length check at start
		.full      (tx_full),
		.empty     ()
	);

	spi_byte_fifo rx_fifo_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.wr        (rx_push),
		.wr_data   (rx_byte),
		.rd        (rx_rd),
		.rd_data   (rx_data),
		.count     (),
		.full      (),				// frame never exceeds depth
		.empty     (rx_empty)
	);

	spi_frame_ctrl spi_frame_ctrl_inst (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.start      (start),
		.frame_len  (frame_len),
		.tx_count   (tx_count),
		.tx_head    (tx_head),
		.byte_done  (byte_done),
		.byte_rx    (byte_rx),
		.busy       (busy),
		.frame_done (frame_done),
		.cs_n       (cs_n),
		.tx_pop     (tx_pop),
		.byte_start (byte_start),
		.byte_tx    (byte_tx),
		.rx_push    (rx_push),
		.rx_byte    (rx_byte)
	);

	spi_byte_engine spi_byte_engine_inst (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.cfg        (cfg),
		.byte_start (byte_start),
		.byte_tx    (byte_tx),
		.miso       (miso),
		.byte_done  (byte_done),
		.byte_rx    (byte_rx),
		.sclk       (sclk),
		.mosi       (mosi)
	);

endmodule

//--- testbench/spi_checker.sv
//**********************************************************************
// watches the dut ports, decodes mosi, predicts rx bytes and accepts
// assumes no tx writes while busy; samples on the rising edge
//**********************************************************************
`timescale 1ns/1ps

module spi_checker
	import spi_pkg::*;
(
	input logic              sys_clk,
	input logic              sys_rst_n,
	input spi_cfg_t          cfg,
	input logic              tx_wr,
	input logic [BYTE_W-1:0] tx_data,
	input logic              tx_full,
	input logic              start,
	input logic [LEN_W-1:0]  frame_len,
	input logic              busy,
	input logic              frame_done,
	input logic              rx_rd,
	input logic [BYTE_W-1:0] rx_data,
	input logic              rx_empty,
	input spi_pins_t         pins,
	input logic [2:0]        test_id
);

	logic [7:0] tx_q [$];
	logic [7:0] rx_q [$];
	int         err_count  = 0;
	int         exp_frames = 0;
	int         done_count = 0;
	int         model_cnt  = 0;
	int         since_edge = 0;
	int         edge_idx   = 0;
	int         bit_cnt    = 0;
	logic [7:0] mosi_sr;
	logic [7:0] prev_byte;
	logic [7:0] exp_b;
	logic       first;
	logic       lead;
	logic       pend;
	logic       pend_exp;
	logic       prev_sclk = 1'b0;
	logic       prev_cs   = 1'b1;
	logic       in_frame  = 1'b0;
	spi_cfg_t   prev_cfg;

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd0:    return "mode0_single";
			3'd1:    return "all_modes_frames";
			3'd2:    return "divider_period";
			3'd3:    return "cs_framing";
			default: return "rejects";
		endcase
	endfunction

	// expected slave answer
	function automatic logic [7:0] slave_answer(input logic first_byte,
		input logic [7:0] prev_mosi);
		return first_byte ? 8'h3C : (prev_mosi ^ 8'hA5);
	endfunction

	task automatic check_val(input string what, input int exp, input int act);
		if (exp != act) begin
			err_count++;
			$display("ERR %s %s expected %0h actual %0h", test_name(test_id), what,
				exp, act);
		end
	endtask

	task automatic final_counts();
		check_val("frame_done count", exp_frames, done_count);
		check_val("tx bytes never sent", 0, tx_q.size());
		check_val("rx bytes never read", 0, rx_q.size());
	endtask

	always @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			model_cnt = 0;
			pend      = 1'b0;
			prev_cs   = 1'b1;
			tx_q.delete();
		end else begin
			if (pend) begin
				check_val("busy after start", pend_exp, busy);
				in_frame = pend_exp;
			end
			pend = 1'b0;
			if (!busy) check_val("tx_full", model_cnt == FIFO_DEPTH, tx_full);
			if (!busy) check_val("rx_empty", rx_q.size() == 0, rx_empty);
			if (tx_wr && model_cnt < FIFO_DEPTH) begin
				tx_q.push_back(tx_data);
				model_cnt++;
			end
			if (start && !busy) begin
				pend     = 1'b1;
				pend_exp = (frame_len != 0) && (frame_len <= model_cnt);
				if (pend_exp) begin
					model_cnt -= frame_len;
					exp_frames++;
				end
			end
			if (frame_done) begin
				done_count++;
				if (!in_frame) begin
					err_count++;
					$display("frame_done pulsed outside of a frame");
				end
				in_frame = 1'b0;
			end
			if (in_frame && !frame_done && pins.cs_n)
				check_val("cs_n inside frame", 0, 1);
			if (!in_frame && !pins.cs_n) begin
				err_count++;
				$display("cs_n low outside of a frame");
			end
			if (rx_rd && !rx_empty) begin
				if (rx_q.size() == 0) begin
					err_count++;
					$display("rx byte read while no byte was expected");
				end else begin
					exp_b = rx_q.pop_front();
					check_val("rx_data", exp_b, rx_data);
				end
			end
			since_edge++;
			if (prev_cs && !pins.cs_n) begin		// cs_n fall
				since_edge = 0;
				edge_idx   = 0;
				bit_cnt    = 0;
				first      = 1'b1;
			end else if (!prev_cs && pins.cs_n) begin
				check_val("cs hold clocks", cfg.clk_div + 1 + CS_HOLD_CYC, since_edge);
			end else if (!pins.cs_n && pins.sclk != prev_sclk) begin
				if (edge_idx == 0 && since_edge < CS_SETUP_CYC)
					check_val("cs setup clocks", CS_SETUP_CYC, since_edge);
				else if (edge_idx % 16 != 0)
					check_val("sclk half period", cfg.clk_div + 2, since_edge);
				edge_idx++;
				since_edge = 0;
				lead = (prev_sclk == cfg.cpol);
				if (lead != cfg.cpha) begin
					mosi_sr = {mosi_sr[6:0], pins.mosi};
					bit_cnt++;
				end
				if (bit_cnt == 8) begin				// byte complete on the pins
					if (tx_q.size() == 0) begin
						err_count++;
						$display("byte sent on mosi that was never written");
					end else begin
						exp_b = tx_q.pop_front();
						check_val("mosi byte", exp_b, mosi_sr);
					end
					rx_q.push_back(slave_answer(first, prev_byte));
					prev_byte = mosi_sr;
					first     = 1'b0;
					bit_cnt   = 0;
				end
			end else if (pins.cs_n && prev_cs && cfg == prev_cfg) begin
				check_val("idle sclk", cfg.cpol, pins.sclk);
			end
		end
		prev_cs   = pins.cs_n;
		prev_sclk = pins.sclk;
		prev_cfg  = cfg;
	end

endmodule

//--- testbench/spi_slave_model.sv
//**********************************************************************
// spi slave model, mode from cfg; first byte answers 8'h3C,
// later bytes answer previous mosi byte xor 8'hA5; acts on falling edge
//**********************************************************************
`timescale 1ns/1ps

module spi_slave_model
	import spi_pkg::*;
(
	input  logic      sys_clk,
	input  spi_cfg_t  cfg,
	input  spi_pins_t pins,
	output logic      miso
);

	logic       prev_sclk = 1'b0;
	logic [7:0] in_sr     = '0;
	logic [7:0] out_byte  = 8'h3C;
	logic [7:0] last_rx   = '0;
	logic       first     = 1'b1;
	logic       lead;
	int         in_cnt    = 0;
	int         out_cnt   = 0;

	initial miso = 1'b0;

	always @(negedge sys_clk) begin
		if (pins.cs_n) begin
			in_cnt   = 0;
			out_cnt  = 0;
			first    = 1'b1;
			out_byte = 8'h3C;
			miso     = out_byte[7];				// ready for cpha 0
		end else if (pins.sclk != prev_sclk) begin
			lead = (prev_sclk == cfg.cpol);
			if (lead != cfg.cpha) begin			// sample edge
				in_sr = {in_sr[6:0], pins.mosi};
				in_cnt++;
				if (in_cnt == 8) begin
					last_rx = in_sr;
					in_cnt  = 0;
				end
			end else if (!cfg.cpha) begin		// trailing edge, mode 0/2
				out_cnt++;
				if (out_cnt == 8) begin
					out_byte = last_rx ^ 8'hA5;
					out_cnt  = 0;
				end
				miso = out_byte[7 - out_cnt];
			end else begin						// leading edge, mode 1/3
				if (out_cnt == 0)
					out_byte = first ? 8'h3C : (last_rx ^ 8'hA5);
				first   = 1'b0;
				miso    = out_byte[7 - out_cnt];
				out_cnt = (out_cnt + 1) % 8;
			end
		end
		prev_sclk = pins.sclk;
	end

endmodule

//--- testbench/tb_spi_subsys.sv
//**********************************************************************
// spi master testbench top; stimulus on falling edge, lfsr stimulus
// host drains rx after every frame, no tx writes while busy
//**********************************************************************
`timescale 1ns/1ps

module tb_spi_subsys
	import spi_pkg::*;
;
	localparam int MAX_FRAMES = 24;			// frames issued, rounded up
	localparam int FRAME_CYC  = 1400;		// 8 bytes at clk_div 7, plus setup/hold

	logic              sys_clk;
	logic              sys_rst_n;
	spi_cfg_t          cfg;
	logic              tx_wr;
	logic [BYTE_W-1:0] tx_data;
	logic              tx_full;
	logic              start;
	logic [LEN_W-1:0]  frame_len;
	logic              busy;
	logic              frame_done;
	logic              rx_rd;
	logic [BYTE_W-1:0] rx_data;
	logic              rx_empty;
	spi_pins_t         pins;
	logic              miso;
	logic [2:0]        test_id;
	logic [31:0]       lfsr = 32'h7c18_6c43;
	int                div_set [4] = '{0, 1, 3, 7};	// divider sweep

	spi_subsys spi_subsys_inst (.*);
	spi_slave_model slave_inst (.sys_clk, .cfg, .pins, .miso);
	spi_checker spi_checker_inst (.*);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic write_bytes(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge sys_clk);
			tx_wr   = 1'b1;
			tx_data = BYTE_W'(rand_bits(8));
		end
		@(negedge sys_clk) tx_wr = 1'b0;
	endtask

	task automatic pulse_start(input int n);
		@(negedge sys_clk);
		start     = 1'b1;
		frame_len = LEN_W'(n);
		@(negedge sys_clk) start = 1'b0;
	endtask

	task automatic finish_frame();
		while (!frame_done) @(negedge sys_clk);
		while (busy) @(negedge sys_clk);
		while (!rx_empty) begin				// drain receive buffer
			rx_rd = 1'b1;
			@(negedge sys_clk) rx_rd = 1'b0;
			@(negedge sys_clk);
		end
	endtask

	task automatic send_frame(input logic [1:0] mode, input int div, input int n);
		@(negedge sys_clk);
		cfg = '{cpol: mode[1], cpha: mode[0], clk_div: DIV_W'(div)};
		write_bytes(n);
		pulse_start(n);
		finish_frame();
	endtask

	initial begin
		repeat (MAX_FRAMES * FRAME_CYC + 2000) @(posedge sys_clk);
		$display("watchdog timeout, the tests did not complete");
		$display("** FAIL **");
		$finish;
	end

	initial begin
		sys_rst_n = 1'b0;
		cfg       = '0;
		tx_wr     = 1'b0;
		tx_data   = '0;
		start     = 1'b0;
		frame_len = '0;
		rx_rd     = 1'b0;
		test_id   = 3'd0;
		repeat (10) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		send_frame(2'd0, 0, 1);				// mode0_single
		test_id = 3'd1;
		for (int m = 0; m < 4; m++)
			for (int f = 0; f < 3; f++)
				send_frame(m[1:0], rand_bits(2), rand_bits(3) + 1);
		test_id = 3'd2;
		for (int i = 0; i < 4; i++)
			send_frame(2'(rand_bits(2)), div_set[i], 2);
		test_id = 3'd3;
		send_frame(2'd3, 2, 8);
		test_id = 3'd4;
		write_bytes(2);
		pulse_start(0);						// zero length
		repeat (20) @(negedge sys_clk);
		pulse_start(3);						// more than buffered
		repeat (20) @(negedge sys_clk);
		@(negedge sys_clk);
		start     = 1'b1;
		frame_len = 2;
		@(negedge sys_clk) frame_len = 1;	// second start lands while busy
		@(negedge sys_clk) start = 1'b0;
		finish_frame();
		write_bytes(9);						// ninth byte dropped
		pulse_start(8);
		finish_frame();
		repeat (10) @(negedge sys_clk);
		spi_checker_inst.final_counts();
		$display("errors: %0d  frames: %0d", spi_checker_inst.err_count,
			spi_checker_inst.done_count);
		if (spi_checker_inst.err_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
